// File: hw/cache_config.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache geometry
// address, line and set widths shared by the package and the stores
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// byte address width
`define ADDR_WIDTH 32

// one line is 32 bytes
`define LINE_WIDTH 256
`define OFFSET_BITS 5

// 8 sets
`define INDEX_BITS 3

// the 3-bit tree replacement only covers four ways
`define NUM_WAYS 4

// rest of the address above index and offset
`define TAG_BITS (`ADDR_WIDTH - `INDEX_BITS - `OFFSET_BITS)

`endif

// File: hw/cache_control.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache controller
// one request in flight, lookup then optional write-back and refill
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cache_control (
    input  logic        clk,
    input  logic        rst,

    // CPU side
    input  logic        mem_read,
    input  logic        mem_write,
    output logic        mem_resp,

    // memory side
    input  logic        pmem_resp,
    output logic        pmem_read,
    output logic        pmem_write,

    cache_ctrl_if.ctrl  bus
);

    cache_pkg::ctrl_state_t state;
    cache_pkg::ctrl_state_t next_state;

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= cache_pkg::IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            cache_pkg::IDLE:
            begin
                if (mem_read || mem_write)
                    next_state = cache_pkg::LOOKUP;
            end
            cache_pkg::LOOKUP:
            begin
                // hit finishes here, miss evicts dirty victim first
                if (bus.hit)
                    next_state = cache_pkg::IDLE;
                else if (bus.victim_dirty)
                    next_state = cache_pkg::WRITE_BACK;
                else
                    next_state = cache_pkg::FILL;
            end
            cache_pkg::WRITE_BACK:
            begin
                if (pmem_resp)
                    next_state = cache_pkg::FILL;
            end
            cache_pkg::FILL:
            begin
                // back to lookup, which now hits
                if (pmem_resp)
                    next_state = cache_pkg::LOOKUP;
            end
            default:
            begin
                next_state = cache_pkg::IDLE;
            end
        endcase
    end

    always_comb
    begin
        mem_resp        = 1'b0;
        pmem_read       = 1'b0;
        pmem_write      = 1'b0;
        bus.plru_update = 1'b0;
        bus.line_src    = cache_pkg::NO_WRITE;
        bus.write_back  = 1'b0;
        bus.fill        = 1'b0;

        case (state)
            cache_pkg::LOOKUP:
            begin
                if (bus.hit)
                begin
                    mem_resp        = 1'b1;
                    bus.plru_update = 1'b1;
                    // write hit also marks the line dirty
                    if (mem_write)
                        bus.line_src = cache_pkg::CPU_WRITE;
                end
            end
            cache_pkg::WRITE_BACK:
            begin
                // held until memory takes the victim line
                pmem_write     = 1'b1;
                bus.write_back = 1'b1;
            end
            cache_pkg::FILL:
            begin
                pmem_read = 1'b1;
                bus.fill  = 1'b1;
                // refill lands with the response
                if (pmem_resp)
                    bus.line_src = cache_pkg::MEM_FILL;
            end
            default:
            begin
                // idle, nothing driven
            end
        endcase
    end

endmodule : cache_control

// File: hw/cache_ctrl_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// controller to datapath link
// strobes from the FSM, lookup and victim results back from the stores
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface cache_ctrl_if;

    // driven by the FSM
    logic                 plru_update;
    cache_pkg::line_src_t line_src;
    logic                 write_back;
    logic                 fill;

    // tag compare results
    logic                 hit;
    cache_pkg::way_vec_t  hit_way;
    cache_pkg::way_vec_t  valid_vec;

    // replacement choice and its dirty bit
    cache_pkg::way_t      victim_way;
    logic                 victim_dirty;

    modport ctrl (
        output plru_update,
        output line_src,
        output write_back,
        output fill,
        input  hit,
        input  victim_dirty
    );

    // shared by the tag, plru and line stores, each drives its own part
    modport store (
        input  plru_update,
        input  line_src,
        input  write_back,
        input  fill,
        output hit,
        output hit_way,
        output valid_vec,
        output victim_way,
        output victim_dirty
    );

endinterface : cache_ctrl_if

// File: hw/cache_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache types
// payload, address field and way types plus the controller enums
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cache_config.svh"

package cache_pkg;

    // byte address and full line payload
    typedef logic [`ADDR_WIDTH-1:0] addr_t;
    typedef logic [`LINE_WIDTH-1:0] line_t;

    // address fields
    typedef logic [`TAG_BITS-1:0]   tag_t;
    typedef logic [`INDEX_BITS-1:0] index_t;

    // way number and one bit per way
    typedef logic [1:0]             way_t;
    typedef logic [`NUM_WAYS-1:0]   way_vec_t;

    // tree bits of one set, {b2, b1, b0}
    typedef logic [2:0]             plru_t;

    // request sequencing
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        WRITE_BACK,
        FILL
    } ctrl_state_t;

    // which source writes the line arrays this cycle
    typedef enum logic [1:0] {
        NO_WRITE,
        CPU_WRITE,
        MEM_FILL
    } line_src_t;

endpackage : cache_pkg

// File: hw/l2_cache.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// four-way write-back L2 cache
// controller plus tag, replacement and line stores on plain ports
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module l2_cache (
    input  logic             clk,
    input  logic             rst,

    // CPU side
    input  cache_pkg::addr_t mem_address,
    input  logic             mem_read,
    input  logic             mem_write,
    input  cache_pkg::line_t mem_wdata,
    output cache_pkg::line_t mem_rdata,
    output logic             mem_resp,

    // memory side
    output cache_pkg::addr_t pmem_address,
    output logic             pmem_read,
    output logic             pmem_write,
    output cache_pkg::line_t pmem_wdata,
    input  cache_pkg::line_t pmem_rdata,
    input  logic             pmem_resp
);

    cache_ctrl_if bus ();

    cache_control u_cache_control (
        .clk        (clk),
        .rst        (rst),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_resp   (mem_resp),
        .pmem_resp  (pmem_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write),
        .bus        (bus.ctrl)
    );

    // hit compare and memory address
    tag_store u_tag_store (
        .clk          (clk),
        .rst          (rst),
        .mem_address  (mem_address),
        .mem_write    (mem_write),
        .pmem_resp    (pmem_resp),
        .pmem_address (pmem_address),
        .bus          (bus.store)
    );

    plru_policy u_plru_policy (
        .clk         (clk),
        .rst         (rst),
        .mem_address (mem_address),
        .bus         (bus.store)
    );

    // line data in both directions
    line_store u_line_store (
        .clk         (clk),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata),
        .pmem_rdata  (pmem_rdata),
        .mem_rdata   (mem_rdata),
        .pmem_wdata  (pmem_wdata),
        .bus         (bus.store)
    );

endmodule : l2_cache

// File: hw/line_store.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// line store
// per-way line arrays with CPU or refill write and the two read ports
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "cache_config.svh"

module line_store (
    input  logic             clk,
    input  cache_pkg::addr_t mem_address,
    input  cache_pkg::line_t mem_wdata,
    input  cache_pkg::line_t pmem_rdata,
    output cache_pkg::line_t mem_rdata,
    output cache_pkg::line_t pmem_wdata,
    cache_ctrl_if.store      bus
);

    localparam int NUM_SETS = 1 << `INDEX_BITS;

    cache_pkg::line_t  line_arr [`NUM_WAYS][NUM_SETS];

    cache_pkg::index_t req_index;
    cache_pkg::way_t   hit_idx;
    cache_pkg::way_t   wr_way;
    cache_pkg::line_t  wr_data;
    logic              wr_en;

    assign req_index = mem_address[`OFFSET_BITS +: `INDEX_BITS];

    // one-hot hit vector to way number
    always_comb
    begin
        hit_idx = '0;
        for (int w = 0; w < `NUM_WAYS; w++)
        begin
            if (bus.hit_way[w])
                hit_idx = cache_pkg::way_t'(w);
        end
    end

    // CPU data into the hit way, memory data into the victim
    always_comb
    begin
        wr_way  = hit_idx;
        wr_data = mem_wdata;
        if (bus.line_src == cache_pkg::MEM_FILL)
        begin
            wr_way  = bus.victim_way;
            wr_data = pmem_rdata;
        end
    end

    assign wr_en = (bus.line_src == cache_pkg::CPU_WRITE)
                   || (bus.fill && bus.line_src == cache_pkg::MEM_FILL);

    always_ff @(posedge clk)
    begin
        if (wr_en)
            line_arr[wr_way][req_index] <= wr_data;
    end

    // hit data to the CPU, victim data to memory
    assign mem_rdata  = line_arr[hit_idx][req_index];
    assign pmem_wdata = line_arr[bus.victim_way][req_index];

endmodule : line_store

// File: hw/plru_policy.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tree pseudo-LRU replacement
// three bits per set, updated on each hit, victim choice on a miss
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "cache_config.svh"

module plru_policy (
    input  logic             clk,
    input  logic             rst,
    input  cache_pkg::addr_t mem_address,
    cache_ctrl_if.store      bus
);

    localparam int NUM_SETS = 1 << `INDEX_BITS;

    // {b2, b1, b0} per set
    cache_pkg::plru_t  plru_arr [NUM_SETS];

    cache_pkg::index_t req_index;
    cache_pkg::plru_t  cur_bits;
    cache_pkg::plru_t  nxt_bits;

    assign req_index = mem_address[`OFFSET_BITS +: `INDEX_BITS];
    assign cur_bits  = plru_arr[req_index];

    // b2 picks the half, b1 or b0 the way inside it
    always_comb
    begin
        nxt_bits = cur_bits;
        if (bus.hit_way[0])
            nxt_bits = {1'b0, 1'b0, cur_bits[0]};
        else if (bus.hit_way[1])
            nxt_bits = {1'b0, 1'b1, cur_bits[0]};
        else if (bus.hit_way[2])
            nxt_bits = {1'b1, cur_bits[1], 1'b0};
        else if (bus.hit_way[3])
            nxt_bits = {1'b1, cur_bits[1], 1'b1};
    end

    // empty ways fill lowest first, tree decides once the set is full
    always_comb
    begin
        if (!bus.valid_vec[0])
            bus.victim_way = 2'd0;
        else if (!bus.valid_vec[1])
            bus.victim_way = 2'd1;
        else if (!bus.valid_vec[2])
            bus.victim_way = 2'd2;
        else if (!bus.valid_vec[3])
            bus.victim_way = 2'd3;
        // last touch was in ways 0/1, evict from 2/3
        else if (!cur_bits[2])
            bus.victim_way = cur_bits[0] ? 2'd2 : 2'd3;
        // otherwise from 0/1
        else
            bus.victim_way = cur_bits[1] ? 2'd0 : 2'd1;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < NUM_SETS; s++)
                plru_arr[s] <= '0;
        end
        else if (bus.plru_update)
        begin
            plru_arr[req_index] <= nxt_bits;
        end
    end

endmodule : plru_policy

// File: hw/tag_store.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tag store
// valid, dirty and tag arrays, four-way hit compare, memory address select
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "cache_config.svh"

module tag_store (
    input  logic             clk,
    input  logic             rst,
    input  cache_pkg::addr_t mem_address,
    input  logic             mem_write,
    input  logic             pmem_resp,
    output cache_pkg::addr_t pmem_address,
    cache_ctrl_if.store      bus
);

    localparam int NUM_SETS = 1 << `INDEX_BITS;

    // per way, per set
    logic              valid_arr [`NUM_WAYS][NUM_SETS];
    logic              dirty_arr [`NUM_WAYS][NUM_SETS];
    cache_pkg::tag_t   tag_arr   [`NUM_WAYS][NUM_SETS];

    cache_pkg::tag_t   req_tag;
    cache_pkg::index_t req_index;
    logic              cpu_wr;
    logic              refill;

    // split the request address
    assign req_tag   = mem_address[`ADDR_WIDTH-1 -: `TAG_BITS];
    assign req_index = mem_address[`OFFSET_BITS +: `INDEX_BITS];

    // write hit lands this edge
    assign cpu_wr = mem_write && (bus.line_src == cache_pkg::CPU_WRITE);
    // refill data returning from memory
    assign refill = bus.fill && pmem_resp && (bus.line_src == cache_pkg::MEM_FILL);

    // compare in all four ways at once
    always_comb
    begin
        for (int w = 0; w < `NUM_WAYS; w++)
        begin
            bus.valid_vec[w] = valid_arr[w][req_index];
            bus.hit_way[w]   = valid_arr[w][req_index] && (tag_arr[w][req_index] == req_tag);
        end
    end

    assign bus.hit = |bus.hit_way;

    // only a valid line can need writing back
    assign bus.victim_dirty = valid_arr[bus.victim_way][req_index]
                              && dirty_arr[bus.victim_way][req_index];

    // victim line address while writing back, else the requested line
    assign pmem_address = bus.write_back
        ? {tag_arr[bus.victim_way][req_index], req_index, {`OFFSET_BITS{1'b0}}}
        : {req_tag, req_index, {`OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int w = 0; w < `NUM_WAYS; w++)
            begin
                for (int s = 0; s < NUM_SETS; s++)
                begin
                    valid_arr[w][s] <= 1'b0;
                    dirty_arr[w][s] <= 1'b0;
                end
            end
        end
        else
        begin
            // fresh line from memory is clean
            if (refill)
            begin
                valid_arr[bus.victim_way][req_index] <= 1'b1;
                dirty_arr[bus.victim_way][req_index] <= 1'b0;
            end
            // mark the written way
            for (int w = 0; w < `NUM_WAYS; w++)
            begin
                if (cpu_wr && bus.hit_way[w])
                    dirty_arr[w][req_index] <= 1'b1;
            end
        end
    end

    // new tag goes in with the refill data
    always_ff @(posedge clk)
    begin
        if (refill)
            tag_arr[bus.victim_way][req_index] <= req_tag;
    end

endmodule : tag_store

// File: list.f
+incdir+hw
hw/cache_pkg.sv
hw/cache_ctrl_if.sv
hw/tag_store.sv
hw/plru_policy.sv
hw/line_store.sv
hw/cache_control.sv
hw/l2_cache.sv
verification/l2_cache_assertions.sv
verification/l2_cache_tb.sv

// File: verification/l2_cache_assertions.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache handshake checks
// bound into the top level, CPU and memory side protocol rules
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module l2_cache_assertions (
    input logic clk,
    input logic rst,
    input logic mem_read,
    input logic mem_write,
    input logic mem_resp,
    input logic pmem_read,
    input logic pmem_write,
    input logic pmem_resp
);

    // failures seen so far, read by the testbench
    int fail_count = 0;

    // response is a single pulse
    resp_one_cycle: assert property (@(posedge clk) disable iff (rst)
        mem_resp |=> !mem_resp)
    else
    begin
        $error("mem_resp held for more than one cycle");
        fail_count++;
    end

    // memory is either read or written, never both
    pmem_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(pmem_read && pmem_write))
    else
    begin
        $error("pmem_read and pmem_write high together");
        fail_count++;
    end

    // request stays up until memory answers
    pmem_read_held: assert property (@(posedge clk) disable iff (rst)
        (pmem_read && !pmem_resp) |=> pmem_read)
    else
    begin
        $error("pmem_read dropped before pmem_resp");
        fail_count++;
    end

    pmem_write_held: assert property (@(posedge clk) disable iff (rst)
        (pmem_write && !pmem_resp) |=> pmem_write)
    else
    begin
        $error("pmem_write dropped before pmem_resp");
        fail_count++;
    end

    // no response without a CPU request
    resp_needs_req: assert property (@(posedge clk) disable iff (rst)
        mem_resp |-> (mem_read || mem_write))
    else
    begin
        $error("mem_resp with no request");
        fail_count++;
    end

endmodule : l2_cache_assertions

bind l2_cache l2_cache_assertions u_l2_cache_assertions (
    .clk        (clk),
    .rst        (rst),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .mem_resp   (mem_resp),
    .pmem_read  (pmem_read),
    .pmem_write (pmem_write),
    .pmem_resp  (pmem_resp)
);

// File: verification/l2_cache_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache testbench
// directed and random CPU traffic checked against a reference cache model,
// with a behavioral memory behind the DUT
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "cache_config.svh"

module l2_cache_tb;

    localparam int NUM_TXN     = 300;
    localparam int MAX_CYCLES  = NUM_TXN * 20;
    localparam int NUM_SETS    = 1 << `INDEX_BITS;
    // three low tag bits plus the index select a memory line
    localparam int SLOT_BITS   = `INDEX_BITS + 3;
    localparam int NUM_SLOTS   = 1 << SLOT_BITS;
    localparam int MEM_LATENCY = 3;
    localparam int NUM_TAGS    = 6;

    typedef struct packed {
        cache_pkg::line_t rdata;
        logic             miss;
        logic             wb;
        cache_pkg::addr_t wb_addr;
        cache_pkg::line_t wb_data;
    } expect_t;

    logic             clk = 1'b0;
    logic             rst;
    cache_pkg::addr_t mem_address;
    logic             mem_read;
    logic             mem_write;
    cache_pkg::line_t mem_wdata;
    cache_pkg::line_t mem_rdata;
    logic             mem_resp;
    cache_pkg::addr_t pmem_address;
    logic             pmem_read;
    logic             pmem_write;
    cache_pkg::line_t pmem_wdata;
    cache_pkg::line_t pmem_rdata;
    logic             pmem_resp;

    // behavioral memory and its predicted image
    cache_pkg::line_t mem     [NUM_SLOTS];
    cache_pkg::line_t ref_mem [NUM_SLOTS];

    // reference cache state
    logic             ref_valid [`NUM_WAYS][NUM_SETS];
    logic             ref_dirty [`NUM_WAYS][NUM_SETS];
    cache_pkg::tag_t  ref_tag   [`NUM_WAYS][NUM_SETS];
    cache_pkg::line_t ref_line  [`NUM_WAYS][NUM_SETS];
    cache_pkg::plru_t ref_plru  [NUM_SETS];

    // current request and what it should do
    expect_t          cur_exp;
    cache_pkg::addr_t cur_addr;
    logic             cur_wr;
    cache_pkg::addr_t last_wb_addr;
    logic             seen_rd;
    logic             seen_wr;
    int               wait_cycles = 0;
    int               txn_count   = 0;
    int               cycle_count = 0;
    integer           seed        = 93009;

    l2_cache u_l2_cache (
        .clk          (clk),
        .rst          (rst),
        .mem_address  (mem_address),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp),
        .pmem_address (pmem_address),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

    always #4 clk = ~clk;

    task automatic check_line(input cache_pkg::line_t got, input cache_pkg::line_t exp,
                              input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "line compare failed");
        end
    endtask

    task automatic check_addr(input cache_pkg::addr_t got, input cache_pkg::addr_t exp,
                              input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "address compare failed");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t ns: %s got %b expected %b", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "flag compare failed");
        end
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display("Test FAILED");
        $fatal(1, "protocol error");
    endtask

    function automatic int line_slot(cache_pkg::addr_t a);
        return int'(a[`OFFSET_BITS +: SLOT_BITS]);
    endfunction

    function automatic cache_pkg::addr_t line_addr(cache_pkg::addr_t a);
        return {a[`ADDR_WIDTH-1:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
    endfunction

    // each word carries its slot and word number
    function automatic cache_pkg::line_t fill_pattern(int slot);
        cache_pkg::line_t l;
        for (int k = 0; k < 8; k++)
            l[k*32 +: 32] = {8'h5a, 8'(slot), 8'(k), 8'(slot * 7 + k)};
        return l;
    endfunction

    function automatic cache_pkg::line_t rand_line();
        cache_pkg::line_t l;
        for (int k = 0; k < 8; k++)
            l[k*32 +: 32] = $random(seed);
        return l;
    endfunction

    // random byte offset, the cache ignores it
    function automatic cache_pkg::addr_t make_addr(int tag, int set);
        logic [`OFFSET_BITS-1:0] off;
        int                      r;
        r   = $random(seed);
        off = r[`OFFSET_BITS-1:0];
        return {cache_pkg::tag_t'(tag), cache_pkg::index_t'(set), off};
    endfunction

    // lowest empty way, else walk the tree away from recent hits
    function automatic int pick_victim(cache_pkg::index_t s);
        cache_pkg::plru_t p;
        p = ref_plru[s];
        for (int w = 0; w < `NUM_WAYS; w++)
        begin
            if (!ref_valid[w][s])
                return w;
        end
        if (!p[2])
            return p[0] ? 2 : 3;
        return p[1] ? 0 : 1;
    endfunction

    // advance the model by one request and predict its outcome
    function automatic expect_t predict(cache_pkg::addr_t a, logic wr, cache_pkg::line_t d);
        expect_t           e;
        cache_pkg::index_t s;
        cache_pkg::tag_t   t;
        int                way;
        e   = '0;
        s   = a[`OFFSET_BITS +: `INDEX_BITS];
        t   = a[`ADDR_WIDTH-1 -: `TAG_BITS];
        way = -1;
        for (int w = 0; w < `NUM_WAYS; w++)
        begin
            if (ref_valid[w][s] && ref_tag[w][s] == t)
                way = w;
        end
        if (way < 0)
        begin
            e.miss = 1'b1;
            way    = pick_victim(s);
            // dirty victim goes to memory before the refill
            if (ref_valid[way][s] && ref_dirty[way][s])
            begin
                e.wb      = 1'b1;
                e.wb_addr = {ref_tag[way][s], s, {`OFFSET_BITS{1'b0}}};
                e.wb_data = ref_line[way][s];
                ref_mem[line_slot(e.wb_addr)] = ref_line[way][s];
            end
            ref_line[way][s]  = ref_mem[line_slot(a)];
            ref_tag[way][s]   = t;
            ref_valid[way][s] = 1'b1;
            ref_dirty[way][s] = 1'b0;
        end
        // response shows the line before a write lands
        e.rdata = ref_line[way][s];
        case (way)
            0: ref_plru[s] = {1'b0, 1'b0, ref_plru[s][0]};
            1: ref_plru[s] = {1'b0, 1'b1, ref_plru[s][0]};
            2: ref_plru[s] = {1'b1, ref_plru[s][1], 1'b0};
            default: ref_plru[s] = {1'b1, ref_plru[s][1], 1'b1};
        endcase
        if (wr)
        begin
            ref_line[way][s]  = d;
            ref_dirty[way][s] = 1'b1;
        end
        return e;
    endfunction

    // one CPU request, held until mem_resp, dropped the cycle after
    task automatic run_request(input cache_pkg::addr_t a, input logic wr);
        cache_pkg::line_t d;
        d = wr ? rand_line() : '0;
        @(posedge clk);
        #1;
        cur_exp     = predict(a, wr, d);
        cur_addr    = a;
        cur_wr      = wr;
        mem_address = a;
        mem_read    = !wr;
        mem_write   = wr;
        mem_wdata   = d;
        @(negedge clk);
        while (!mem_resp)
            @(negedge clk);
        @(posedge clk);
        #1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        txn_count++;
    endtask

    // memory answers after a fixed latency
    initial
    begin
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        forever
        begin
            @(negedge clk);
            if (!rst && (pmem_read || pmem_write))
            begin
                repeat (MEM_LATENCY) @(posedge clk);
                #1;
                if (pmem_write)
                    mem[line_slot(pmem_address)] = pmem_wdata;
                else
                    pmem_rdata = mem[line_slot(pmem_address)];
                pmem_resp = 1'b1;
                @(posedge clk);
                #1;
                pmem_resp = 1'b0;
            end
        end
    end

    // compare every response and memory access with the prediction
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (u_l2_cache.u_l2_cache_assertions.fail_count != 0)
                report_error("a handshake assertion failed");
            if (mem_read || mem_write)
            begin
                if (wait_cycles == 0)
                begin
                    seen_rd = 1'b0;
                    seen_wr = 1'b0;
                end
                if (pmem_write && !seen_wr)
                begin
                    check_flag(cur_exp.wb, 1'b1, "write-back of a dirty victim");
                    check_flag(seen_rd, 1'b0, "write-back ahead of refill");
                    check_addr(pmem_address, cur_exp.wb_addr, "write-back address");
                    check_line(pmem_wdata, cur_exp.wb_data, "write-back data");
                    last_wb_addr = pmem_address;
                    seen_wr      = 1'b1;
                end
                if (pmem_read && !seen_rd)
                begin
                    check_flag(cur_exp.miss, 1'b1, "refill on a miss");
                    check_addr(pmem_address, line_addr(cur_addr), "refill address");
                    seen_rd = 1'b1;
                end
                if (mem_resp)
                begin
                    check_flag(seen_rd, cur_exp.miss, "refill seen");
                    check_flag(seen_wr, cur_exp.wb, "write-back seen");
                    if (!cur_exp.miss)
                        check_flag(wait_cycles == 1, 1'b1, "hit response one cycle late");
                    if (!cur_wr)
                        check_line(mem_rdata, cur_exp.rdata, "read data");
                end
                wait_cycles++;
            end
            else
            begin
                wait_cycles = 0;
                if (mem_resp)
                    report_error("mem_resp with no request pending");
                if (pmem_read || pmem_write)
                    report_error("memory access with no request pending");
            end
        end
    end

    // run limit from the request count
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("ERROR: timeout after %0d cycles, %0d requests done",
                     cycle_count, txn_count);
            $display("Test FAILED");
            $fatal(1, "simulation timeout");
        end
    end

    initial
    begin
        int tag_sel;
        int set_sel;
        int r;
        rst         = 1'b1;
        mem_address = '0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_wdata   = '0;
        for (int i = 0; i < NUM_SLOTS; i++)
        begin
            mem[i]     = fill_pattern(i);
            ref_mem[i] = fill_pattern(i);
        end
        for (int s = 0; s < NUM_SETS; s++)
        begin
            ref_plru[s] = '0;
            for (int w = 0; w < `NUM_WAYS; w++)
            begin
                ref_valid[w][s] = 1'b0;
                ref_dirty[w][s] = 1'b0;
            end
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // cold read from memory, then the same line hits
        run_request(make_addr(0, 0), 1'b0);
        run_request(make_addr(0, 0), 1'b0);
        // write hit then read back
        run_request(make_addr(0, 0), 1'b1);
        run_request(make_addr(0, 0), 1'b0);

        // dirty lines into ways 0..3 of set 1, no write-back yet
        for (int t = 0; t < 4; t++)
            run_request(make_addr(t, 1), 1'b1);
        // hits on ways 2 then 0 leave way 3 as the tree victim
        run_request(make_addr(2, 1), 1'b0);
        run_request(make_addr(0, 1), 1'b0);
        run_request(make_addr(4, 1), 1'b0);
        check_addr(last_wb_addr, line_addr(make_addr(3, 1)), "tree victim line");
        run_request(make_addr(5, 1), 1'b0);

        // clean set, fifth tag evicts with no write-back
        for (int t = 0; t < 5; t++)
            run_request(make_addr(t, 2), 1'b0);

        // random mix over a few tags per set
        while (txn_count < NUM_TXN)
        begin
            tag_sel = $unsigned($random(seed)) % NUM_TAGS;
            set_sel = $unsigned($random(seed)) % NUM_SETS;
            r       = $random(seed);
            run_request(make_addr(tag_sel, set_sel), r[0]);
        end

        repeat (2) @(posedge clk);
        for (int i = 0; i < NUM_SLOTS; i++)
            check_line(mem[i], ref_mem[i], "memory image");

        if (u_l2_cache.u_l2_cache_assertions.fail_count == 0)
        begin
            $display("Test OK");
            $finish;
        end
        else
        begin
            $display("ERROR: handshake assertions failed during the run");
            $display("Test FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule : l2_cache_tb
